/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - hw/frontend_pkg.sv
      - hw/instr_fifo_bank.sv
      - hw/instr_buffer.sv
      - hw/fetch_pc_counter.sv
      - hw/fetch_ctrl.sv
      - hw/instr_predecode.sv
      - hw/frontend_top.sv
  - target: test
    files:
      - bench/tb_frontend.sv

/* bench/frontend_testdata.txt */
// 64-word instruction image, eight words per line, from address 0
00500093 fff08113 00812183 00208863 002081b3 123452b7 ffc12203 fe209ce3
7ff00313 80030393 00042403 0003a483 00a48463 01f00513 40b50533 fe0508e3
00158593 ffe60613 01c6a683 00d69263 00000013 abcde737 0047a783 80000863
7e0786e3 00178793 fff7c793 0087f813 00482883 0108c063 00b50933 fc0916e3
00c00993 00498993 ff89aa03 0149c463 fe9a0a93 000aab03 01ea8a63 40000bb7
06400c13 f9cc0c13 018c2c83 fd9c1ee3 00100d13 00cd2d83 7c0d8263 0000006f
00300e13 ff4e0e13 fe0e2e83 01de1063 123e8f13 7fff2f83 81ff8fe3 00008067
00a00093 80108113 00412183 fe3108e3 003100b3 0010a213 ffd20293 00028363
// Number of steps
30
// Steps, four per line: accept mask, flush flag, redirect target
0 0 0   0 0 0   0 0 0   0 0 0
0 0 0   0 0 0   0 0 0   0 0 0
0 0 0   0 0 0   3 0 0   3 0 0
3 0 0   1 0 0   3 0 0   2 0 0
1 0 0   3 0 0   3 0 0   0 1 40
1 0 0   3 0 0   3 0 0   3 0 0
0 1 2c  3 0 0   1 0 0   3 0 0
0 0 0   0 0 0   0 0 0   0 0 0
0 0 0   0 0 0   0 0 0   0 0 0
3 0 0   3 0 0   3 0 0   0 1 f4
3 0 0   1 0 0   3 0 0   3 0 0
0 1 10  3 0 0   3 0 0   1 0 0

/* bench/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;
    import frontend_pkg::*;

    localparam int IMAGE_WORDS = 64;
    localparam int MAX_STEPS   = 48;
    localparam int STEP_BASE   = IMAGE_WORDS + 1;

    logic                              clk;
    logic                              reset_i;
    logic                              imem_req_o;
    logic [XLEN-1:0]                   imem_addr_o;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  imem_rdata_i;
    logic                              flush_i;
    logic [XLEN-1:0]                   redirect_pc_i;
    logic [DECODE_WIDTH-1:0]           accept_i;
    logic [DECODE_WIDTH-1:0]           slot_valid_o;
    logic [DECODE_WIDTH-1:0][XLEN-1:0] slot_pc_o;
    logic [DECODE_WIDTH-1:0][XLEN-1:0] slot_instr_o;
    instr_class_e [DECODE_WIDTH-1:0]   slot_class_o;
    logic [DECODE_WIDTH-1:0][XLEN-1:0] slot_imm_o;
    logic                              stall_o;

    // Memory image, step count, then {mask, flush, target} per step
    logic [31:0] tdata [0:STEP_BASE+3*MAX_STEPS-1];
    integer      seed;
    int          num_steps;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          k;
    int          reps;
    logic [1:0]  step_mask;
    logic        step_flush;
    logic [31:0] step_target;

    // Reference model state
    int          held;
    int          rsp_words;
    int          cyc_n;
    logic [31:0] rsp_addr;
    logic [31:0] exp_pc;
    logic [31:0] fetch_ref;
    logic        stall_prev;
    logic        stall_seen;

    frontend_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .accept_i      (accept_i),
        .slot_valid_o  (slot_valid_o),
        .slot_pc_o     (slot_pc_o),
        .slot_instr_o  (slot_instr_o),
        .slot_class_o  (slot_class_o),
        .slot_imm_o    (slot_imm_o),
        .stall_o       (stall_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("program did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] image_word(input logic [31:0] addr);
        return tdata[addr[7:2]];
    endfunction

    function automatic instr_class_e expected_class(input logic [31:0] w);
        case (w[6:0])
            7'b0010011: return CLS_ALU_IMM;
            7'b0000011: return CLS_LOAD;
            7'b1100011: return CLS_BRANCH;
            default:    return CLS_OTHER;
        endcase
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
            7'b0010011, 7'b0000011: return {{20{w[31]}}, w[31:20]};
            7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            default:    return 32'd0;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("mismatch at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // One cycle: serve memory, check outputs, drive inputs, advance the model
    task automatic step_cycle(input logic [1:0] req_mask, input logic do_flush,
                              input logic [31:0] target);
        logic [DECODE_WIDTH-1:0] acc;
        logic [31:0]             slot_exp;
        logic                    stall_exp;
        logic                    req_exp;
        int                      n_acc;
        int                      s;
        imem_rdata_i[0] = tdata[{rsp_addr[7:3], 1'b0}];
        imem_rdata_i[1] = tdata[{rsp_addr[7:3], 1'b1}];

        stall_exp = (held > IBUF_SIZE - IBUF_STALL_FREE);
        check_value("slot_valid_o[0]", 32'(held >= 1), 32'(slot_valid_o[0]));
        check_value("slot_valid_o[1]", 32'(held >= 2), 32'(slot_valid_o[1]));
        check_value("stall_o", 32'(stall_exp), 32'(stall_o));
        for (s = 0; s < DECODE_WIDTH; s++) begin
            slot_exp = exp_pc + 32'(4 * s);
            if (slot_valid_o[s]) begin
                check_value($sformatf("slot_pc_o[%0d]", s), slot_exp, slot_pc_o[s]);
                check_value($sformatf("slot_instr_o[%0d]", s), image_word(slot_exp),
                            slot_instr_o[s]);
                check_value($sformatf("slot_class_o[%0d]", s),
                            32'(expected_class(image_word(slot_exp))), 32'(slot_class_o[s]));
                check_value($sformatf("slot_imm_o[%0d]", s),
                            expected_imm(image_word(slot_exp)), slot_imm_o[s]);
            end else begin
                check_value($sformatf("slot_class_o[%0d]", s), 32'(CLS_OTHER),
                            32'(slot_class_o[s]));
                check_value($sformatf("slot_imm_o[%0d]", s), 32'd0, slot_imm_o[s]);
            end
        end

        // One IDLE cycle after reset, one HOLD cycle after each stalled cycle
        req_exp = (cyc_n >= 1) && !stall_exp && !stall_prev;
        check_value("imem_req_o", 32'(req_exp), 32'(imem_req_o));
        if (req_exp) begin
            check_value("imem_addr_o", {fetch_ref[31:3], 3'b000}, imem_addr_o);
        end

        acc[0] = req_mask[0] & slot_valid_o[0] & !do_flush;
        acc[1] = req_mask[1] & acc[0] & slot_valid_o[1];
        accept_i      = acc;
        flush_i       = do_flush;
        redirect_pc_i = target;
        n_acc = int'(acc[0]) + int'(acc[1]);

        if (do_flush) begin
            held      = 0;
            rsp_words = 0;
            exp_pc    = target;
            fetch_ref = target;
        end else begin
            held      = held + rsp_words - n_acc;
            exp_pc    = exp_pc + 32'(4 * n_acc);
            rsp_words = 0;
            if (req_exp) begin
                // Words below a misaligned target are dropped
                rsp_words = FETCH_WIDTH - int'(fetch_ref[2]);
                fetch_ref = {fetch_ref[31:3], 3'b000} + 32'd8;
            end
        end
        if (imem_req_o) rsp_addr = imem_addr_o;
        stall_prev = stall_exp;
        if (stall_o) stall_seen = 1'b1;

        @(posedge clk);
        #2;
        cyc_n++;
    endtask

    initial begin
        seed          = 36;
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        accept_i      = '0;
        imem_rdata_i  = '0;
        held          = 0;
        rsp_words     = 0;
        cyc_n         = 0;
        rsp_addr      = '0;
        exp_pc        = '0;
        fetch_ref     = '0;
        stall_prev    = 1'b0;
        stall_seen    = 1'b0;

        $readmemh("bench/frontend_testdata.txt", tdata);
        num_steps = int'(tdata[IMAGE_WORDS]);
        assert (num_steps > 0 && num_steps <= MAX_STEPS)
            else abort_run("step count in the data file is missing or out of range");
        cycle_limit = 8 * num_steps + 50;

        repeat (3) @(posedge clk);
        #2;
        reset_i = 1'b0;

        for (k = 0; k < num_steps; k++) begin
            step_mask   = tdata[STEP_BASE + 3 * k][1:0];
            step_flush  = tdata[STEP_BASE + 3 * k + 1][0];
            step_target = tdata[STEP_BASE + 3 * k + 2];
            if (step_flush) begin
                step_cycle(2'b00, 1'b1, step_target);
            end else begin
                // Each mask is held for a random 1 to 4 cycles
                reps = 1 + ({$random(seed)} % 4);
                repeat (reps) step_cycle(step_mask, 1'b0, 32'd0);
            end
        end

        assert (stall_seen) begin
            $display("sim passed");
        end else begin
            abort_run("stall_o never rose while accepts were withheld");
        end
        $finish;
    end

endmodule

/* hw/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                                                         clk,
    input  logic                                                         reset_i,
    input  logic                                                         flush_i,
    input  logic                                                         stall_i,
    input  logic [frontend_pkg::XLEN-1:0]                                pc_i,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] imem_rdata_i,
    output logic                                                         advance_o,
    output logic                                                         imem_req_o,
    output logic [frontend_pkg::XLEN-1:0]                                imem_addr_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0]                         push_valid_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] push_pc_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0] push_word_o
);
    import frontend_pkg::*;

    logic [1:0]            state_q;
    logic [1:0]            state_d;
    logic                  rsp_pend_q;
    logic [XLEN-1:0]       req_pc_q;
    logic [XLEN-1:0]       group_base;
    logic [WORD_OFS_W-1:0] word_ofs;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  state_d = ST_FETCH;
            ST_FETCH: if (stall_i) state_d = ST_HOLD;
            ST_HOLD:  if (!stall_i) state_d = ST_FETCH;
            default:  state_d = ST_IDLE;
        endcase
    end

    assign imem_req_o  = (state_q == ST_FETCH) && !stall_i;
    assign imem_addr_o = {pc_i[XLEN-1:GROUP_OFS_W], {GROUP_OFS_W{1'b0}}};
    assign advance_o   = imem_req_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            rsp_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Request made during a flush belongs to the old path
            rsp_pend_q <= imem_req_o && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            req_pc_q <= pc_i;
        end
    end

    assign group_base = {req_pc_q[XLEN-1:GROUP_OFS_W], {GROUP_OFS_W{1'b0}}};
    assign word_ofs   = req_pc_q[GROUP_OFS_W-1:GROUP_OFS_W-WORD_OFS_W];

    // Words ahead of a misaligned target are not part of the stream
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            push_valid_o[i] = rsp_pend_q && (i >= word_ofs);
            push_pc_o[i]    = group_base + XLEN'(i * INSTR_BYTES);
            push_word_o[i]  = imem_rdata_i[i];
        end
    end

endmodule

/* hw/fetch_pc_counter.sv */
`timescale 1ns/1ps

module fetch_pc_counter (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          advance_i,
    input  logic                          redirect_i,
    input  logic [frontend_pkg::XLEN-1:0] redirect_pc_i,
    output logic [frontend_pkg::XLEN-1:0] pc_o
);
    import frontend_pkg::*;

    logic [XLEN-1:0]             pc_q;
    logic [XLEN-GROUP_OFS_W-1:0] next_group;

    // Step drops the offset, so a misaligned target realigns here
    assign next_group = pc_q[XLEN-1:GROUP_OFS_W] + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (advance_i) begin
            pc_q <= {next_group, {GROUP_OFS_W{1'b0}}};
        end
    end

    assign pc_o = pc_q;

endmodule

/* hw/frontend_pkg.sv */
package frontend_pkg;

    localparam int XLEN            = 32;
    localparam int FETCH_WIDTH     = 2;
    localparam int DECODE_WIDTH    = 2;
    localparam int INSTR_BYTES     = XLEN / 8;
    localparam int GROUP_OFS_W     = $clog2(FETCH_WIDTH * INSTR_BYTES);
    localparam int WORD_OFS_W      = $clog2(FETCH_WIDTH);

    // Instruction buffer geometry
    localparam int IBUF_CHANNEL    = 4;
    localparam int IBUF_SIZE       = 16;
    localparam int BANK_DEPTH      = IBUF_SIZE / IBUF_CHANNEL;
    localparam int IBUF_STALL_FREE = 4;
    localparam int IBUF_IDX_W      = $clog2(IBUF_CHANNEL);
    localparam int IBUF_OCC_W      = $clog2(IBUF_SIZE + 1);
    localparam int BANK_PTR_W      = $clog2(BANK_DEPTH);
    localparam int BANK_CNT_W      = $clog2(BANK_DEPTH + 1);
    localparam int PUSH_CNT_W      = $clog2(FETCH_WIDTH + 1);
    localparam int POP_CNT_W       = $clog2(DECODE_WIDTH + 1);

    // Slot entry is {pc, word}
    localparam int SLOT_W          = 2 * XLEN;
    localparam int SLOT_PC_LSB     = XLEN;

    // Fetch FSM encodings
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_HOLD  = 2'd2;

    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;

    typedef enum logic [1:0] {
        CLS_OTHER,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_BRANCH
    } instr_class_e;

    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_type;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b_type;
    } instr_word_u;

endpackage

/* hw/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                                                          clk,
    input  logic                                                          reset_i,
    output logic                                                          imem_req_o,
    output logic [frontend_pkg::XLEN-1:0]                                 imem_addr_o,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  imem_rdata_i,
    input  logic                                                          flush_i,
    input  logic [frontend_pkg::XLEN-1:0]                                 redirect_pc_i,
    input  logic [frontend_pkg::DECODE_WIDTH-1:0]                         accept_i,
    output logic [frontend_pkg::DECODE_WIDTH-1:0]                         slot_valid_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0][frontend_pkg::XLEN-1:0] slot_pc_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0][frontend_pkg::XLEN-1:0] slot_instr_o,
    output frontend_pkg::instr_class_e [frontend_pkg::DECODE_WIDTH-1:0]   slot_class_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0][frontend_pkg::XLEN-1:0] slot_imm_o,
    output logic                                                          stall_o
);
    import frontend_pkg::*;

    logic [XLEN-1:0]                   fetch_pc;
    logic                              pc_advance;
    logic                              stall;
    logic [FETCH_WIDTH-1:0]            push_valid;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  push_pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0]  push_word;
    logic [POP_CNT_W-1:0]              pop_count;

    fetch_pc_counter u_pc (
        .clk           (clk),
        .reset_i       (reset_i),
        .advance_i     (pc_advance),
        .redirect_i    (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (fetch_pc)
    );

    fetch_ctrl u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .stall_i      (stall),
        .pc_i         (fetch_pc),
        .imem_rdata_i (imem_rdata_i),
        .advance_o    (pc_advance),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .push_valid_o (push_valid),
        .push_pc_o    (push_pc),
        .push_word_o  (push_word)
    );

    // Only accepts on valid slots count toward the pop
    always_comb begin
        pop_count = '0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            pop_count = pop_count + POP_CNT_W'(accept_i[i] & slot_valid_o[i]);
        end
    end

    instr_buffer u_ibuf (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid),
        .push_pc_i    (push_pc),
        .push_word_i  (push_word),
        .pop_count_i  (pop_count),
        .stall_o      (stall),
        .head_valid_o (slot_valid_o),
        .head_pc_o    (slot_pc_o),
        .head_word_o  (slot_instr_o)
    );

    for (genvar s = 0; s < DECODE_WIDTH; s++) begin : gen_predecode
        instr_predecode u_predecode (
            .valid_i (slot_valid_o[s]),
            .word_i  (slot_instr_o[s]),
            .class_o (slot_class_o[s]),
            .imm_o   (slot_imm_o[s])
        );
    end

    assign stall_o = stall;

endmodule

/* hw/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  logic                                                 flush_i,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0]                 push_valid_i,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  push_pc_i,
    input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::XLEN-1:0]  push_word_i,
    input  logic [frontend_pkg::POP_CNT_W-1:0]                   pop_count_i,
    output logic                                                 stall_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0]                head_valid_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0][frontend_pkg::XLEN-1:0] head_pc_o,
    output logic [frontend_pkg::DECODE_WIDTH-1:0][frontend_pkg::XLEN-1:0] head_word_o
);
    import frontend_pkg::*;

    logic [IBUF_CHANNEL-1:0]             bank_push;
    logic [IBUF_CHANNEL-1:0]             bank_pop;
    logic [IBUF_CHANNEL-1:0]             bank_empty;
    logic [IBUF_CHANNEL-1:0][SLOT_W-1:0] bank_wdata;
    logic [IBUF_CHANNEL-1:0][SLOT_W-1:0] bank_rdata;

    logic [FETCH_WIDTH-1:0][SLOT_W-1:0]  packed_data;
    logic [PUSH_CNT_W-1:0]               push_num;
    logic [IBUF_IDX_W-1:0]               rd_ptr_q;
    logic [IBUF_IDX_W-1:0]               wr_ptr_q;
    logic [IBUF_OCC_W-1:0]               occ_q;
    logic [IBUF_OCC_W-1:0]               free_cnt;

    // Squeeze valid inputs down to a prefix and count them
    always_comb begin
        push_num    = '0;
        packed_data = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (push_valid_i[i]) begin
                packed_data[push_num] = {push_pc_i[i], push_word_i[i]};
                push_num = push_num + 1'b1;
            end
        end
    end

    // Item i lands in bank wr_ptr + i
    always_comb begin
        logic [IBUF_IDX_W-1:0] idx;
        bank_push  = '0;
        bank_wdata = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            idx = wr_ptr_q + IBUF_IDX_W'(i);
            if (i < push_num) begin
                bank_push[idx]  = 1'b1;
                bank_wdata[idx] = packed_data[i];
            end
        end
    end

    // Slot s reads bank rd_ptr + s; banks fill contiguously so emptiness gives the prefix
    always_comb begin
        logic [IBUF_IDX_W-1:0] idx;
        bank_pop = '0;
        for (int s = 0; s < DECODE_WIDTH; s++) begin
            idx = rd_ptr_q + IBUF_IDX_W'(s);
            head_valid_o[s] = !bank_empty[idx];
            head_pc_o[s]    = bank_rdata[idx][SLOT_W-1:SLOT_PC_LSB];
            head_word_o[s]  = bank_rdata[idx][SLOT_PC_LSB-1:0];
            if (s < pop_count_i) begin
                bank_pop[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + IBUF_IDX_W'(pop_count_i);
            wr_ptr_q <= wr_ptr_q + IBUF_IDX_W'(push_num);
            occ_q    <= occ_q + IBUF_OCC_W'(push_num) - IBUF_OCC_W'(pop_count_i);
        end
    end

    assign free_cnt = IBUF_OCC_W'(IBUF_SIZE) - occ_q;

    // Room for the response in flight plus one more group
    assign stall_o = (free_cnt < IBUF_OCC_W'(IBUF_STALL_FREE));

    for (genvar b = 0; b < IBUF_CHANNEL; b++) begin : gen_bank
        instr_fifo_bank u_bank (
            .clk         (clk),
            .reset_i     (reset_i),
            .clear_i     (flush_i),
            .push_i      (bank_push[b]),
            .push_data_i (bank_wdata[b]),
            .pop_i       (bank_pop[b]),
            .pop_data_o  (bank_rdata[b]),
            .full_o      (),
            .empty_o     (bank_empty[b])
        );
    end

endmodule

/* hw/instr_fifo_bank.sv */
`timescale 1ns/1ps

module instr_fifo_bank (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            clear_i,
    input  logic                            push_i,
    input  logic [frontend_pkg::SLOT_W-1:0] push_data_i,
    input  logic                            pop_i,
    output logic [frontend_pkg::SLOT_W-1:0] pop_data_o,
    output logic                            full_o,
    output logic                            empty_o
);
    import frontend_pkg::*;

    logic [SLOT_W-1:0]     mem [BANK_DEPTH];
    logic [BANK_PTR_W-1:0] rd_ptr_q;
    logic [BANK_PTR_W-1:0] wr_ptr_q;
    logic [BANK_CNT_W-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;

    assign full_o  = (count_q == BANK_CNT_W'(BANK_DEPTH));
    assign empty_o = (count_q == '0);

    // A full bank still takes a push when it pops on the same edge
    assign do_push = push_i && (!full_o || pop_i);
    assign do_pop  = pop_i && !empty_o;

    assign pop_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + BANK_CNT_W'(do_push) - BANK_CNT_W'(do_pop);
        end
    end

endmodule

/* hw/instr_predecode.sv */
`timescale 1ns/1ps

module instr_predecode (
    input  logic                           valid_i,
    input  logic [frontend_pkg::XLEN-1:0]  word_i,
    output frontend_pkg::instr_class_e     class_o,
    output logic [frontend_pkg::XLEN-1:0]  imm_o
);
    import frontend_pkg::*;

    instr_word_u instr;

    assign instr = word_i;

    always_comb begin
        class_o = CLS_OTHER;
        imm_o   = '0;
        if (valid_i) begin
            case (instr.i_type.opcode)
                OPC_ALU_IMM: begin
                    class_o = CLS_ALU_IMM;
                    imm_o   = {{(XLEN-12){instr.i_type.imm12[11]}}, instr.i_type.imm12};
                end
                OPC_LOAD: begin
                    class_o = CLS_LOAD;
                    imm_o   = {{(XLEN-12){instr.i_type.imm12[11]}}, instr.i_type.imm12};
                end
                OPC_BRANCH: begin
                    class_o = CLS_BRANCH;
                    // 13-bit offset, halfword aligned
                    imm_o   = {{(XLEN-12){instr.b_type.imm12}},
                               instr.b_type.imm11,
                               instr.b_type.imm10_5,
                               instr.b_type.imm4_1,
                               1'b0};
                end
                default: begin
                    class_o = CLS_OTHER;
                    imm_o   = '0;
                end
            endcase
        end
    end

endmodule

/* tb.f */
hw/frontend_pkg.sv
hw/instr_fifo_bank.sv
hw/instr_buffer.sv
hw/fetch_pc_counter.sv
hw/fetch_ctrl.sv
hw/instr_predecode.sv
hw/frontend_top.sv
bench/tb_frontend.sv
